/* tb.f */
hdl/cordic_pkg.sv
hdl/cordic_fsm.sv
hdl/cordic_var_regs.sv
hdl/cordic_operand_sel.sv
hdl/cordic_output_stage.sv
hdl/cordic_coprocessor.sv
sim/cordic_chk.sv
sim/cordic_tb.sv

/* sim/cordic_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cordic_tb;
	import cordic_pkg::*;

	localparam int CLK_PERIOD     = 40;      // ns.
	localparam int RESET_CYCLES   = 10;
	localparam int SEED           = 76336;
	localparam int N_SWEEP        = 7;       // Angles from -0.78 to 0.78.
	localparam int N_RAND         = 8;
	localparam int NUM_TESTS      = 2 * N_SWEEP + 16 + N_RAND + 2;
	localparam int REQS_PER_TEST  = 96;      // Three adder requests per iteration.
	localparam int CYCLES_PER_REQ = 12;
	localparam int WATCHDOG_NS    = NUM_TESTS * REQS_PER_TEST * CYCLES_PER_REQ * CLK_PERIOD
	                              + (RESET_CYCLES + 40) * CLK_PERIOD;

	logic    clk;
	logic    rst;
	logic    beg_fsm_cordic;
	logic    ack_cordic;
	logic    operation;
	logic    ready_add_subt;
	word_t   data_in;
	region_t shift_region_flag;
	word_t   result_add_subt;
	logic    ready_cordic;
	logic    beg_add_subt;
	logic    ack_add_subt;
	logic    op_add_subt;
	word_t   add_subt_data_a;
	word_t   add_subt_data_b;
	word_t   data_output;

	logic [31:0] lcg_state = SEED;     // Shared by the adder delays and the host.
	word_t       exp_q [$];            // Expected results in request order.
	word_t       expected;
	word_t       held_output;          // data_output when ready_cordic rose.
	logic        ready_seen = 1'b0;
	logic        host_idle  = 1'b1;    // Set from a result until the next start pulse.
	int          result_count = 0;

	cordic_coprocessor cordic_coprocessor_i
	(
		.clk               (clk),
		.rst               (rst),
		.beg_fsm_cordic    (beg_fsm_cordic),
		.ack_cordic        (ack_cordic),
		.operation         (operation),
		.ready_add_subt    (ready_add_subt),
		.data_in           (data_in),
		.shift_region_flag (shift_region_flag),
		.result_add_subt   (result_add_subt),
		.ready_cordic      (ready_cordic),
		.beg_add_subt      (beg_add_subt),
		.ack_add_subt      (ack_add_subt),
		.op_add_subt       (op_add_subt),
		.add_subt_data_a   (add_subt_data_a),
		.add_subt_data_b   (add_subt_data_b),
		.data_output       (data_output)
	);

	////////////////////////////////////////
	// Helpers.

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic expect_word(input string name, input word_t got, input word_t exp);
		assert (got === exp)
		else
			fail_now($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	// Linear congruential generator with 15 bits out.
	function automatic int next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[30:16]);
	endfunction

	function automatic word_t to_word(input real r);
		shortreal s;
		s = r;
		return $shortrealtobits(s);
	endfunction

	// Single precision add or subtract, rounded to binary32.
	function automatic word_t add_sub_float(input word_t a, input word_t b, input logic sub);
		shortreal fa;
		shortreal fb;
		shortreal r;
		fa = $bitstoshortreal(a);
		fb = $bitstoshortreal(b);
		r  = sub ? fa - fb : fa + fb;
		return $shortrealtobits(r);
	endfunction

	// Multiplies by 2^-n by lowering the exponent and gives zero on underflow.
	function automatic word_t scale_pow2(input word_t w, input int n);
		int e;
		e = w[30:23];
		if (e == 0 || e <= n)
			return '0;
		return {w[31], 8'(e - n), w[22:0]};
	endfunction

	// Rotation mode CORDIC on binary32 words followed by the region sign fix.
	function automatic word_t cordic_reference(input word_t angle, input logic sine,
	                                           input region_t region);
		word_t x;
		word_t y;
		word_t z;
		word_t xs;
		word_t ys;
		word_t res;
		logic  d;
		logic  neg;
		int    i;
		x = X_INIT;
		y = '0;
		z = angle;
		for (i = 0; i < ITER_N; i++)
		begin
			d  = z[31];                        // Negative Z rotates the other way.
			xs = scale_pow2(x, i);
			ys = scale_pow2(y, i);
			x  = add_sub_float(x, ys, !d);     // Old Y is still in y here.
			y  = add_sub_float(y, xs, d);
			z  = add_sub_float(z, ATAN_LUT[i], !d);
		end
		res = sine ? y : x;
		neg = sine ? (region == REGION_2 || region == REGION_3)
		           : (region == REGION_1 || region == REGION_2);
		res[31] = res[31] ^ neg;
		return res;
	endfunction

	////////////////////////////////////////
	// Clock, watchdog and adder model.

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		fail_now("Timeout: the run did not finish within its time limit.");
	end

	// Answers each request after 0 to 7 cycles and holds ready until the ack.
	initial
	begin : adder_model
		word_t op_a;
		word_t op_b;
		logic  op_sub;
		int    delay;
		ready_add_subt  = 1'b0;
		result_add_subt = '0;
		forever
		begin
			@(posedge clk);
			if (!rst)
				expect_word("ack_add_subt", word_t'(ack_add_subt), word_t'(1'b0));
			if (!rst && beg_add_subt === 1'b1)
			begin
				op_a   = add_subt_data_a;
				op_b   = add_subt_data_b;
				op_sub = op_add_subt;
				delay  = next_rand() % 8;
				@(negedge clk);
				repeat (delay) @(negedge clk);
				result_add_subt = add_sub_float(op_a, op_b, op_sub);
				ready_add_subt  = 1'b1;
				@(posedge clk);
				expect_word("add_subt_data_a", add_subt_data_a, op_a);   // Held until ack.
				expect_word("add_subt_data_b", add_subt_data_b, op_b);
				expect_word("op_add_subt", word_t'(op_add_subt), word_t'(op_sub));
				// The DUT is already waiting, so it acks in the first ready cycle.
				expect_word("ack_add_subt", word_t'(ack_add_subt), word_t'(1'b1));
				@(negedge clk);
				ready_add_subt = 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// Comparison of results and handshake monitor.

	always @(posedge clk)
	begin
		if (!rst)
		begin
			assert (cordic_coprocessor_i.cordic_fsm_i.cordic_chk_i.fail_count == 0)
			else
				fail_now("A handshake assertion in cordic_chk failed.");
			assert (!(host_idle && beg_add_subt === 1'b1))
			else
				fail_now("An adder request appeared before the next start pulse.");
			if (ready_cordic && !ready_seen)
			begin
				assert (exp_q.size() != 0)
				else
					fail_now("ready_cordic rose with no request outstanding.");
				expected = exp_q.pop_front();
				expect_word("data_output", data_output, expected);
				held_output = data_output;
				result_count++;
				host_idle = 1'b1;
			end
			else if (ready_cordic)
				expect_word("data_output", data_output, held_output);   // Must not move.
			ready_seen = ready_cordic;
		end
	end

	////////////////////////////////////////
	// Stimulus.

	// One computation with an optional second start pulse while it runs.
	task automatic run_case(input word_t angle, input logic sine, input region_t region,
	                        input bit extra_start);
		int ack_wait;
		exp_q.push_back(cordic_reference(angle, sine, region));
		@(negedge clk);
		data_in           = angle;
		operation         = sine;
		shift_region_flag = region;
		beg_fsm_cordic    = 1'b1;
		host_idle         = 1'b0;
		@(negedge clk);
		beg_fsm_cordic    = 1'b0;
		data_in           = ~angle;    // The inputs only count on the start edge.
		operation         = ~sine;
		shift_region_flag = ~region;
		if (extra_start)
		begin
			repeat (20) @(negedge clk);
			beg_fsm_cordic = 1'b1;     // The FSM is busy and should ignore this.
			@(negedge clk);
			beg_fsm_cordic = 1'b0;
		end
		while (ready_cordic !== 1'b1)
			@(negedge clk);
		ack_wait = next_rand() % 6;
		repeat (ack_wait) @(negedge clk);
		ack_cordic = 1'b1;
		@(negedge clk);
		ack_cordic = 1'b0;
	endtask

	initial
	begin : stimulus
		int k;
		int r;
		int s;
		real a;
		rst               = 1'b1;
		beg_fsm_cordic    = 1'b0;
		ack_cordic        = 1'b0;
		operation         = 1'b0;
		data_in           = '0;
		shift_region_flag = REGION_NONE;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Cosine and sine over the whole range without a region fix.
		for (k = 0; k < N_SWEEP; k++)
		begin
			a = -0.78 + 0.26 * k;
			run_case(to_word(a), 1'b0, REGION_NONE, 1'b0);
			run_case(to_word(a), 1'b1, REGION_NONE, 1'b0);
		end

		// Every region flag with both functions and both signs of angle.
		for (r = 0; r < 4; r++)
		begin
			for (s = 0; s < 2; s++)
			begin
				run_case(to_word(0.5), s[0], region_t'(r), 1'b0);
				run_case(to_word(-0.3), s[0], region_t'(r), 1'b0);
			end
		end

		// Random angles, functions and regions.
		for (k = 0; k < N_RAND; k++)
		begin
			a = -0.78 + 1.56 * real'(next_rand()) / 32767.0;
			s = next_rand() % 2;
			r = next_rand() % 4;
			run_case(to_word(a), s[0], region_t'(r), 1'b0);
		end

		// Start pulses sent in the middle of a computation.
		run_case(to_word(0.6), 1'b1, REGION_1, 1'b1);
		run_case(to_word(-0.7), 1'b0, REGION_3, 1'b1);

		repeat (20) @(negedge clk);   // The monitor keeps watching the idle adder.
		if (result_count == NUM_TESTS && exp_q.size() == 0)
		begin
			$display("Finished with no errors");
			$finish;
		end
		else
			fail_now("Not every start pulse produced exactly one result.");
	end

endmodule

`default_nettype wire

/* sim/cordic_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module cordic_chk
(
	input logic clk,
	input logic rst,
	input logic beg_add_subt,
	input logic ready_cordic,
	input logic ack_cordic
);
	int unsigned fail_count = 0;   // Number of failed handshake properties.

	// An adder request is a single-cycle strobe.
	beg_one_cycle: assert property (@(posedge clk) disable iff (rst)
		beg_add_subt |=> !beg_add_subt)
	else
	begin
		$error("beg_add_subt stayed high for more than one cycle.");
		fail_count++;
	end

	// While a result is offered to the host the adder is left alone.
	no_beg_while_ready: assert property (@(posedge clk) disable iff (rst)
		ready_cordic |-> !beg_add_subt)
	else
	begin
		$error("beg_add_subt rose while ready_cordic was high.");
		fail_count++;
	end

	// The result is offered until the host takes it.
	ready_until_ack: assert property (@(posedge clk) disable iff (rst)
		ready_cordic && !ack_cordic |=> ready_cordic)
	else
	begin
		$error("ready_cordic fell before ack_cordic.");
		fail_count++;
	end

endmodule

bind cordic_fsm cordic_chk cordic_chk_i
(
	.clk          (clk),
	.rst          (rst),
	.beg_add_subt (beg_add_subt),
	.ready_cordic (ready_cordic),
	.ack_cordic   (ack_cordic)
);

`default_nettype wire

/* hdl/cordic_coprocessor.sv */
`timescale 1ns/10ps
`default_nettype none

module cordic_coprocessor
(
	input  logic                clk,                // System clock.
	input  logic                rst,                // Synchronous reset, active high.
	input  logic                beg_fsm_cordic,     // Start pulse from the host.
	input  logic                ack_cordic,         // Host has taken the result.
	input  logic                operation,          // 1 for sine, 0 for cosine.
	input  logic                ready_add_subt,     // Adder result is valid.
	input  cordic_pkg::word_t   data_in,            // Angle in radians.
	input  cordic_pkg::region_t shift_region_flag,  // Quadrant of the original angle.
	input  cordic_pkg::word_t   result_add_subt,    // Sum or difference from the adder.
	output logic                ready_cordic,       // Result is held on data_output.
	output logic                beg_add_subt,       // Starts one adder operation.
	output logic                ack_add_subt,       // Adder result was captured.
	output logic                op_add_subt,        // 0 adds, 1 subtracts.
	output cordic_pkg::word_t   add_subt_data_a,
	output cordic_pkg::word_t   add_subt_data_b,
	output cordic_pkg::word_t   data_output         // Final sine or cosine.
);
	import cordic_pkg::*;

	////////////////////////////////////////
	// Control from the FSM to the datapath.

	logic  load_init;      // Start edge.
	logic  load_work;      // Working registers take a new set.
	logic  sel_iterate;    // Working set comes from the last iteration.
	logic  load_operands;  // Shifted words, table entry and sign are sampled.
	logic  load_result;    // Adder result goes to the register of cur_var.
	logic  load_out;       // Raw result is selected.
	logic  load_final;     // Sign corrected result is stored.
	var_t  cur_var;
	iter_t iter;

	// Datapath values between the stages.
	word_t x_work;
	word_t y_work;
	word_t z_work;
	word_t x_new;
	word_t y_new;

	cordic_fsm cordic_fsm_i
	(
		.clk            (clk),
		.rst            (rst),
		.beg_fsm_cordic (beg_fsm_cordic),
		.ack_cordic     (ack_cordic),
		.ready_add_subt (ready_add_subt),
		.ready_cordic   (ready_cordic),
		.beg_add_subt   (beg_add_subt),
		.ack_add_subt   (ack_add_subt),
		.load_init      (load_init),
		.load_work      (load_work),
		.sel_iterate    (sel_iterate),
		.load_operands  (load_operands),
		.load_result    (load_result),
		.load_out       (load_out),
		.load_final     (load_final),
		.cur_var        (cur_var),
		.iter           (iter)
	);

	cordic_var_regs cordic_var_regs_i
	(
		.clk             (clk),
		.rst             (rst),
		.load_init       (load_init),
		.load_work       (load_work),
		.sel_iterate     (sel_iterate),
		.load_result     (load_result),
		.cur_var         (cur_var),
		.data_in         (data_in),
		.result_add_subt (result_add_subt),
		.x_work          (x_work),
		.y_work          (y_work),
		.z_work          (z_work),
		.x_new           (x_new),
		.y_new           (y_new)
	);

	cordic_operand_sel cordic_operand_sel_i
	(
		.clk             (clk),
		.rst             (rst),
		.load_operands   (load_operands),
		.cur_var         (cur_var),
		.iter            (iter),
		.x_work          (x_work),
		.y_work          (y_work),
		.z_work          (z_work),
		.add_subt_data_a (add_subt_data_a),
		.add_subt_data_b (add_subt_data_b),
		.op_add_subt     (op_add_subt)
	);

	cordic_output_stage cordic_output_stage_i
	(
		.clk               (clk),
		.rst               (rst),
		.operation         (operation),
		.shift_region_flag (shift_region_flag),
		.load_init         (load_init),
		.load_out          (load_out),
		.load_final        (load_final),
		.x_new             (x_new),
		.y_new             (y_new),
		.data_output       (data_output)
	);

endmodule

`default_nettype wire

/* hdl/cordic_output_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module cordic_output_stage
(
	input  logic                clk,
	input  logic                rst,
	input  logic                operation,
	input  cordic_pkg::region_t shift_region_flag,
	input  logic                load_init,
	input  logic                load_out,
	input  logic                load_final,
	input  cordic_pkg::word_t   x_new,
	input  cordic_pkg::word_t   y_new,
	output cordic_pkg::word_t   data_output
);
	import cordic_pkg::*;

	logic    op_q;       // Sine when set.
	region_t region_q;
	word_t   res_q;      // Result before the sign correction.
	logic    negate;

	// The request is held for the whole computation.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			op_q     <= 1'b0;
			region_q <= REGION_NONE;
		end
		else if (load_init)
		begin
			op_q     <= operation;
			region_q <= shift_region_flag;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			res_q <= '0;
		else if (load_out)
			res_q <= op_q ? y_new : x_new;   // Y holds the sine, X the cosine.
	end

	// Cosine is negative in regions 1 and 2, sine in regions 2 and 3.
	assign negate = op_q ? (region_q == REGION_2 || region_q == REGION_3)
	                     : (region_q == REGION_1 || region_q == REGION_2);

	always_ff @(posedge clk)
	begin
		if (rst)
			data_output <= '0;
		else if (load_final)
			data_output <= {res_q[WORD_W-1] ^ negate, res_q[WORD_W-2:0]};
	end

endmodule

`default_nettype wire

/* hdl/cordic_operand_sel.sv */
`timescale 1ns/10ps
`default_nettype none

module cordic_operand_sel
(
	input  logic              clk,
	input  logic              rst,
	input  logic              load_operands,
	input  cordic_pkg::var_t  cur_var,
	input  cordic_pkg::iter_t iter,
	input  cordic_pkg::word_t x_work,
	input  cordic_pkg::word_t y_work,
	input  cordic_pkg::word_t z_work,
	output cordic_pkg::word_t add_subt_data_a,
	output cordic_pkg::word_t add_subt_data_b,
	output logic              op_add_subt
);
	import cordic_pkg::*;

	word_t x_sh_q;    // 2^-i times X.
	word_t y_sh_q;    // 2^-i times Y.
	word_t lut_q;     // arctan(2^-i).
	logic  sign_q;    // Direction d, the sign of the working Z.

	// Multiplies by 2^-n through the exponent field. Zero, and anything
	// that would underflow, becomes plus zero.
	function automatic word_t shift_word(input word_t w, input iter_t n);
		logic [EXP_W-1:0] e;
		e = w[WORD_W-2 -: EXP_W];
		if (e == '0 || e <= EXP_W'(n))
			return '0;
		return {w[WORD_W-1], e - EXP_W'(n), w[MAN_W-1:0]};
	endfunction

	////////////////////////////////////////
	// Operand registers, loaded once per iteration.

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			x_sh_q <= '0;
			y_sh_q <= '0;
			lut_q  <= '0;
			sign_q <= 1'b0;
		end
		else if (load_operands)
		begin
			x_sh_q <= shift_word(x_work, iter);
			y_sh_q <= shift_word(y_work, iter);
			lut_q  <= ATAN_LUT[iter];
			sign_q <= z_work[WORD_W-1];
		end
	end

	////////////////////////////////////////
	// Adder operands and operation.

	// With d set, X adds, Y subtracts and Z adds. Otherwise each is reversed.
	always_comb
	begin
		add_subt_data_a = '0;
		add_subt_data_b = '0;
		op_add_subt     = 1'b0;
		case (cur_var)
			VAR_X:
			begin
				add_subt_data_a = x_work;
				add_subt_data_b = y_sh_q;
				op_add_subt     = ~sign_q;
			end
			VAR_Y:
			begin
				add_subt_data_a = y_work;
				add_subt_data_b = x_sh_q;
				op_add_subt     = sign_q;
			end
			VAR_Z:
			begin
				add_subt_data_a = z_work;
				add_subt_data_b = lut_q;
				op_add_subt     = ~sign_q;
			end
			default: ;   // Unused code, operands stay zero.
		endcase
	end

endmodule

`default_nettype wire

/* hdl/cordic_var_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module cordic_var_regs
(
	input  logic              clk,
	input  logic              rst,
	input  logic              load_init,
	input  logic              load_work,
	input  logic              sel_iterate,
	input  logic              load_result,
	input  cordic_pkg::var_t  cur_var,
	input  cordic_pkg::word_t data_in,
	input  cordic_pkg::word_t result_add_subt,
	output cordic_pkg::word_t x_work,
	output cordic_pkg::word_t y_work,
	output cordic_pkg::word_t z_work,
	output cordic_pkg::word_t x_new,
	output cordic_pkg::word_t y_new
);
	import cordic_pkg::*;

	word_t z_init_q;   // Angle of the running computation.
	word_t z_new;      // Z after the last completed update.

	// The angle is the only start value that differs between computations.
	always_ff @(posedge clk)
	begin
		if (rst)
			z_init_q <= '0;
		else if (load_init)
			z_init_q <= data_in;   // The angle is the start value of Z.
	end

	// The working set stays frozen for a whole iteration, so all three
	// updates see the values from before it.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			x_work <= '0;
			y_work <= '0;
			z_work <= '0;
		end
		else if (load_work)
		begin
			x_work <= sel_iterate ? x_new : X_INIT;
			y_work <= sel_iterate ? y_new : Y_INIT;
			z_work <= sel_iterate ? z_new : z_init_q;
		end
	end

	// Only the register of the variable in flight takes the adder result.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			x_new <= '0;
			y_new <= '0;
			z_new <= '0;
		end
		else if (load_result)
		begin
			case (cur_var)
				VAR_X: x_new <= result_add_subt;
				VAR_Y: y_new <= result_add_subt;
				VAR_Z: z_new <= result_add_subt;
				default: ;   // No fourth variable.
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/cordic_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module cordic_fsm
(
	input  logic              clk,
	input  logic              rst,
	input  logic              beg_fsm_cordic,
	input  logic              ack_cordic,
	input  logic              ready_add_subt,
	output logic              ready_cordic,
	output logic              beg_add_subt,
	output logic              ack_add_subt,
	output logic              load_init,
	output logic              load_work,
	output logic              sel_iterate,
	output logic              load_operands,
	output logic              load_result,
	output logic              load_out,
	output logic              load_final,
	output cordic_pkg::var_t  cur_var,
	output cordic_pkg::iter_t iter
);
	import cordic_pkg::*;

	typedef enum logic [3:0]
	{
		S_IDLE,
		S_LOAD,       // Working registers are loaded.
		S_FETCH,      // Shifted operands and table entry are sampled.
		S_REQUEST,    // One adder request.
		S_WAIT,       // Waits as long as the adder needs.
		S_CAPTURE,    // Waits for the adder to drop ready.
		S_NEXT_VAR,
		S_NEXT_ITER,
		S_OUTPUT,
		S_DONE
	} state_t;

	state_t state;
	state_t state_next;
	logic   start;       // Start pulse accepted.
	logic   last_iter;   // Counter is on the final iteration.

	assign start     = (state == S_IDLE) && beg_fsm_cordic;  // Ignored when busy.
	assign last_iter = (iter == iter_t'(ITER_N - 1));

	////////////////////////////////////////
	// State sequencing.

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= S_IDLE;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			S_IDLE:
				if (beg_fsm_cordic)
					state_next = S_LOAD;
			S_LOAD:
				state_next = S_FETCH;
			S_FETCH:
				state_next = S_REQUEST;
			S_REQUEST:
				state_next = S_WAIT;
			S_WAIT:
				// The last Z update ends the loop straight away.
				if (ready_add_subt && cur_var == VAR_Z && last_iter)
					state_next = S_OUTPUT;
				else if (ready_add_subt)
					state_next = S_CAPTURE;
			S_CAPTURE:
				if (!ready_add_subt)
					state_next = S_NEXT_VAR;
			S_NEXT_VAR:
				if (cur_var == VAR_Z)
					state_next = S_NEXT_ITER;
				else
					state_next = S_REQUEST;
			S_NEXT_ITER:
				state_next = S_LOAD;
			S_OUTPUT:
				state_next = S_DONE;
			S_DONE:
				if (ready_cordic && ack_cordic)
					state_next = S_IDLE;   // Back to idle one cycle after the ack.
			default:
				state_next = S_IDLE;
		endcase
	end

	////////////////////////////////////////
	// Strobes decoded from the state.

	assign load_init     = start;
	assign load_work     = (state == S_LOAD);
	assign sel_iterate   = (iter != '0);   // Only iteration zero starts from the initial set.
	assign load_operands = (state == S_FETCH);
	assign beg_add_subt  = (state == S_REQUEST);
	assign ack_add_subt  = (state == S_WAIT) && ready_add_subt;  // Same cycle as the capture.
	assign load_result   = (state == S_WAIT) && ready_add_subt;
	assign load_out      = (state == S_OUTPUT);

	// The corrected word is stored one cycle after the raw select.
	always_ff @(posedge clk)
	begin
		if (rst)
			load_final <= 1'b0;
		else
			load_final <= load_out;
	end

	// Ready rises together with data_output and holds until the host acks.
	always_ff @(posedge clk)
	begin
		if (rst)
			ready_cordic <= 1'b0;
		else if (load_final)
			ready_cordic <= 1'b1;
		else if (ack_cordic)
			ready_cordic <= 1'b0;
	end

	////////////////////////////////////////
	// Iteration and variable counters.

	always_ff @(posedge clk)
	begin
		if (rst || start)
			iter <= '0;
		else if (state == S_NEXT_ITER)
			iter <= iter + 1'b1;   // Counts up through the iterations.
	end

	always_ff @(posedge clk)
	begin
		if (rst || start)
			cur_var <= VAR_X;
		else if (state == S_NEXT_VAR)
		begin
			// X, then Y, then Z, then X again for the next iteration.
			if (cur_var == VAR_Z)
				cur_var <= VAR_X;
			else
				cur_var <= cur_var + 2'd1;
		end
	end

endmodule

`default_nettype wire

/* hdl/cordic_pkg.sv */
`default_nettype none

package cordic_pkg;

	////////////////////////////////////////
	// Word format and iteration count.

	localparam int WORD_W = 32;            // Binary32 word.
	localparam int EXP_W  = 8;             // Biased exponent field.
	localparam int MAN_W  = 23;            // Fraction field without the hidden bit.
	localparam int ITER_N = 32;            // One iteration per bit of the word.
	localparam int ITER_W = 5;             // Enough to count ITER_N iterations.

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ITER_W-1:0] iter_t;

	// Names the variable whose update is in flight on the adder.
	typedef logic [1:0] var_t;

	localparam var_t VAR_X = 2'd0;
	localparam var_t VAR_Y = 2'd1;
	localparam var_t VAR_Z = 2'd2;

	////////////////////////////////////////
	// Start values and the arctangent table.

	localparam word_t X_INIT = 32'h3f1b74ee;   // Inverse CORDIC gain, about 0.6072529.
	localparam word_t Y_INIT = 32'h00000000;   // Y starts at zero.

	// Entry i is arctan(2^-i). From i = 12 on the table is simply 2^-i.
	localparam word_t ATAN_LUT [ITER_N] = '{
		32'h3f490fdb, 32'h3eed6338, 32'h3e7adbb0, 32'h3dfeadd5,
		32'h3d7faade, 32'h3cffeaae, 32'h3c7ffaab, 32'h3bfffeab,
		32'h3b7fffab, 32'h3affffeb, 32'h3a7ffffb, 32'h39ffffff,
		32'h39800000, 32'h39000000, 32'h38800000, 32'h38000000,
		32'h37800000, 32'h37000000, 32'h36800000, 32'h36000000,
		32'h35800000, 32'h35000000, 32'h34800000, 32'h34000000,
		32'h33800000, 32'h33000000, 32'h32800000, 32'h32000000,
		32'h31800000, 32'h31000000, 32'h30800000, 32'h30000000
	};

	////////////////////////////////////////
	// Region flag from the host.

	// Tells in which quadrant the original angle lay before it was folded.
	typedef logic [1:0] region_t;

	localparam region_t REGION_NONE = 2'b00;   // Angle already inside the CORDIC range.
	localparam region_t REGION_1    = 2'b01;
	localparam region_t REGION_2    = 2'b10;
	localparam region_t REGION_3    = 2'b11;

endpackage

`default_nettype wire
